// ==== rtl/cart_pkg.sv ====
package cart_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [23:0] addr_t;
   typedef logic [15:0] len_t;

   // upper nibble of the command byte
   typedef enum logic [3:0] {
      op_set_addr = 4'h0,
      op_set_mask = 4'h1,
      op_fill     = 4'h4,
      op_read     = 4'h8,
      op_write    = 4'h9,
      op_info     = 4'hF
   } cmd_op_t;

   typedef enum logic [1:0] {
      dec_idle,
      dec_param,
      dec_wait_credit
   } dec_state_t;

   typedef enum logic {
      fill_idle,
      fill_run
   } fill_state_t;

   // identity reply for 0xF0
   localparam byte_t ID_BYTE = 8'hA5;

endpackage

// ==== rtl/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if
   import cart_pkg::*;
();

   // request side
   logic  req_valid;
   logic  req_write;
   addr_t req_addr;
   byte_t req_wdata;

   // return side
   logic  credit_ret;
   byte_t rdata;
   logic  rvalid;

   modport requester (
      output req_valid, req_write, req_addr, req_wdata,
      input  credit_ret, rdata, rvalid
   );

   modport arbiter (
      input  req_valid, req_write, req_addr, req_wdata,
      output credit_ret, rdata, rvalid
   );

endinterface

// ==== rtl/mcu_cmd_decoder.sv ====
`timescale 1ns/1ps

module mcu_cmd_decoder
   import cart_pkg::*;
#(
   parameter int CREDITS = 2
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  byte_valid,
   input  logic  byte_first,
   input  byte_t byte_in,
   input  logic  fill_busy,
   output logic  reply_valid,
   output byte_t reply_byte,
   output logic  fill_start,
   output addr_t fill_addr,
   output addr_t fill_mask,
   output len_t  fill_len,
   output byte_t fill_value,
   mem_req_if.requester mem
);

   localparam int CNT_W = $clog2(CREDITS + 1);

   dec_state_t       state;
   byte_t            cmd_r;
   cmd_op_t          op;
   logic [1:0]       param_idx;
   addr_t            ptr;
   addr_t            mask;
   len_t             len_r;
   logic [CNT_W-1:0] credits;
   logic [CNT_W-1:0] cred_now;
   logic             param_byte;
   logic             access;
   logic             info_byte;

   assign op         = cmd_op_t'(cmd_r[7:4]);
   assign param_byte = byte_valid && !byte_first && (state == dec_param);
   assign access     = param_byte && ((op == op_write) || (op == op_read));
   assign info_byte  = param_byte && (op == op_info);

   // value byte of a fill frame starts the engine
   assign fill_start = param_byte && (op == op_fill) && (param_idx == 2'd2);
   assign fill_value = byte_in;
   assign fill_addr  = ptr;
   assign fill_mask  = mask;
   assign fill_len   = len_r;

   // credits still free once the request on the bus is debited
   assign cred_now = credits + CNT_W'(mem.credit_ret) - CNT_W'(mem.req_valid);

   ////////////////////
   // control
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state         <= dec_idle;
         cmd_r         <= '0;
         param_idx     <= '0;
         ptr           <= '0;
         mask          <= '1;
         credits       <= CNT_W'(CREDITS);
         mem.req_valid <= 1'b0;
         reply_valid   <= 1'b0;
      end else begin
         credits       <= cred_now;
         mem.req_valid <= 1'b0;
         reply_valid   <= mem.rvalid || info_byte;
         case (state)
            dec_idle, dec_param: begin
               if (byte_valid && byte_first) begin
                  cmd_r     <= byte_in;
                  param_idx <= '0;
                  state     <= dec_param;
               end else if (param_byte) begin
                  if (param_idx != 2'd3) begin
                     param_idx <= param_idx + 2'd1;
                  end
                  case (op)
                     op_set_addr: begin
                        case (param_idx)
                           2'd0: ptr <= {byte_in, 16'h0000};
                           2'd1: ptr[15:8] <= byte_in;
                           2'd2: ptr[7:0] <= byte_in;
                           default: ;
                        endcase
                     end
                     op_set_mask: begin
                        case (param_idx)
                           2'd0: mask <= {byte_in, 16'h0000};
                           2'd1: mask[15:8] <= byte_in;
                           2'd2: mask[7:0] <= byte_in;
                           default: ;
                        endcase
                     end
                     op_write, op_read: begin
                        ptr <= ptr + 24'd1;
                        if (cred_now != '0) begin
                           mem.req_valid <= 1'b1;
                        end else begin
                           state <= dec_wait_credit;
                        end
                     end
                     default: ;
                  endcase
               end
            end
            dec_wait_credit: begin
               // access already latched, send once a credit is back
               if (cred_now != '0) begin
                  mem.req_valid <= 1'b1;
                  state         <= dec_param;
               end
            end
            default: state <= dec_idle;
         endcase
      end
   end

   ////////////////////
   // payload
   ////////////////////

   always_ff @(posedge clk) begin
      if (mem.rvalid) begin
         reply_byte <= mem.rdata;
      end else if (info_byte) begin
         reply_byte <= (cmd_r[3:0] == 4'h1) ? {fill_busy, 7'b0} : ID_BYTE;
      end
      if (access) begin
         mem.req_write <= (op == op_write);
         mem.req_addr  <= ptr & mask;
         mem.req_wdata <= byte_in;
      end
      // length arrives high byte first
      if (param_byte && (op == op_fill)) begin
         if (param_idx == 2'd0) begin
            len_r[15:8] <= byte_in;
         end else if (param_idx == 2'd1) begin
            len_r[7:0] <= byte_in;
         end
      end
   end

   a_req_has_credit: assert property (@(posedge clk) disable iff (rst)
      mem.req_valid |-> credits != '0);

   // SPI pacing must leave room for a parked access
   a_no_byte_while_parked: assert property (@(posedge clk) disable iff (rst)
      state == dec_wait_credit |-> !byte_valid);

endmodule

// ==== rtl/fill_engine.sv ====
`timescale 1ns/1ps

module fill_engine
   import cart_pkg::*;
#(
   parameter int CREDITS = 2
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  fill_start,
   input  addr_t fill_addr,
   input  addr_t fill_mask,
   input  len_t  fill_len,
   input  byte_t fill_value,
   output logic  fill_busy,
   mem_req_if.requester mem
);

   localparam int CNT_W = $clog2(CREDITS + 1);

   fill_state_t      state;
   len_t             remaining;
   addr_t            cur_addr;
   addr_t            mask_r;
   byte_t            value_r;
   logic [CNT_W-1:0] credits;
   logic [CNT_W-1:0] cred_now;
   logic             issue;

   assign cred_now  = credits + CNT_W'(mem.credit_ret) - CNT_W'(mem.req_valid);
   assign issue     = (state == fill_run) && (remaining != '0) && (cred_now != '0);
   assign fill_busy = (state == fill_run);
   assign mem.req_write = 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         state         <= fill_idle;
         remaining     <= '0;
         credits       <= CNT_W'(CREDITS);
         mem.req_valid <= 1'b0;
      end else begin
         credits       <= cred_now;
         mem.req_valid <= issue;
         case (state)
            fill_idle: begin
               if (fill_start && (fill_len != '0)) begin
                  remaining <= fill_len;
                  state     <= fill_run;
               end
            end
            fill_run: begin
               if (issue) begin
                  remaining <= remaining - 16'd1;
               end else if ((remaining == '0) && !mem.req_valid &&
                            (cred_now == CNT_W'(CREDITS))) begin
                  // every write has left the arbiter queue
                  state <= fill_idle;
               end
            end
            default: state <= fill_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == fill_idle) && fill_start) begin
         cur_addr <= fill_addr;
         mask_r   <= fill_mask;
         value_r  <= fill_value;
      end else if (issue) begin
         mem.req_addr  <= cur_addr & mask_r;
         mem.req_wdata <= value_r;
         cur_addr      <= cur_addr + 24'd1;
      end
   end

   a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
      fill_start |-> !fill_busy);

   a_req_has_credit: assert property (@(posedge clk) disable iff (rst)
      mem.req_valid |-> credits != '0);

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
   import cart_pkg::*;
#(
   parameter int ADDR_W  = 12,
   parameter int CREDITS = 2
) (
   input  logic              clk,
   input  logic              rst,
   mem_req_if.arbiter        dec,
   mem_req_if.arbiter        fill,
   output logic              ram_en,
   output logic              ram_we,
   output logic [ADDR_W-1:0] ram_addr,
   output byte_t             ram_wdata,
   input  byte_t             ram_rdata
);

   localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
   localparam int CNT_W = $clog2(CREDITS + 1);

   // port 0 is the decoder, port 1 the fill engine
   logic              push     [2];
   logic              in_we    [2];
   logic [ADDR_W-1:0] in_addr  [2];
   byte_t             in_data  [2];
   logic              nonempty [2];
   logic              grant    [2];

   logic              q_we   [2][CREDITS];
   logic [ADDR_W-1:0] q_addr [2][CREDITS];
   byte_t             q_data [2][CREDITS];
   logic [PTR_W-1:0]  wr_ptr [2];
   logic [PTR_W-1:0]  rd_ptr [2];
   logic [CNT_W-1:0]  count  [2];

   logic              rr_last;
   logic              sel;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(CREDITS - 1)) ? '0 : p + 1'b1;
   endfunction

   assign push[0]    = dec.req_valid;
   assign in_we[0]   = dec.req_write;
   assign in_addr[0] = dec.req_addr[ADDR_W-1:0];
   assign in_data[0] = dec.req_wdata;
   assign push[1]    = fill.req_valid;
   assign in_we[1]   = fill.req_write;
   assign in_addr[1] = fill.req_addr[ADDR_W-1:0];
   assign in_data[1] = fill.req_wdata;

   assign nonempty[0] = (count[0] != '0);
   assign nonempty[1] = (count[1] != '0);

   ////////////////////
   // round robin
   ////////////////////

   // rr_last high means the fill port went last
   assign grant[1] = nonempty[1] && (!nonempty[0] || !rr_last);
   assign grant[0] = nonempty[0] && !grant[1];
   assign sel      = grant[1];

   assign ram_en    = grant[0] || grant[1];
   assign ram_we    = q_we[sel][rd_ptr[sel]];
   assign ram_addr  = q_addr[sel][rd_ptr[sel]];
   assign ram_wdata = q_data[sel][rd_ptr[sel]];

   assign dec.credit_ret  = grant[0];
   assign fill.credit_ret = grant[1];
   assign dec.rdata       = ram_rdata;
   assign fill.rdata      = ram_rdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         rr_last     <= 1'b0;
         dec.rvalid  <= 1'b0;
         fill.rvalid <= 1'b0;
         for (int p = 0; p < 2; p++) begin
            wr_ptr[p] <= '0;
            rd_ptr[p] <= '0;
            count[p]  <= '0;
         end
      end else begin
         if (ram_en) begin
            rr_last <= sel;
         end
         // RAM answers one cycle after the grant
         dec.rvalid  <= grant[0] && !ram_we;
         fill.rvalid <= grant[1] && !ram_we;
         for (int p = 0; p < 2; p++) begin
            if (push[p]) begin
               wr_ptr[p] <= next_ptr(wr_ptr[p]);
            end
            if (grant[p]) begin
               rd_ptr[p] <= next_ptr(rd_ptr[p]);
            end
            case ({push[p], grant[p]})
               2'b10:   count[p] <= count[p] + 1'b1;
               2'b01:   count[p] <= count[p] - 1'b1;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int p = 0; p < 2; p++) begin
         if (push[p]) begin
            q_we[p][wr_ptr[p]]   <= in_we[p];
            q_addr[p][wr_ptr[p]] <= in_addr[p];
            q_data[p][wr_ptr[p]] <= in_data[p];
         end
      end
   end

   // requesters must respect their credit count
   for (genvar p = 0; p < 2; p++) begin : g_chk
      a_no_overflow: assert property (@(posedge clk) disable iff (rst)
         push[p] |-> count[p] != CNT_W'(CREDITS));
   end

endmodule

// ==== rtl/save_ram.sv ====
`timescale 1ns/1ps

module save_ram
   import cart_pkg::*;
#(
   parameter int ADDR_W = 12
) (
   input  logic              clk,
   input  logic              ram_en,
   input  logic              ram_we,
   input  logic [ADDR_W-1:0] ram_addr,
   input  byte_t             ram_wdata,
   output byte_t             ram_rdata
);

   byte_t mem [2**ADDR_W];

   // single port, read data registered
   always_ff @(posedge clk) begin
      if (ram_en) begin
         if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
         end else begin
            ram_rdata <= mem[ram_addr];
         end
      end
   end

endmodule

// ==== rtl/cart_cmd_top.sv ====
`timescale 1ns/1ps

module cart_cmd_top
   import cart_pkg::*;
#(
   parameter int ADDR_W  = 12,
   parameter int CREDITS = 2
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  byte_valid,
   input  logic  byte_first,
   input  byte_t byte_in,
   output logic  reply_valid,
   output byte_t reply_byte,
   output logic  fill_busy
);

   logic              fill_start;
   addr_t             fill_addr;
   addr_t             fill_mask;
   len_t              fill_len;
   byte_t             fill_value;

   logic              ram_en;
   logic              ram_we;
   logic [ADDR_W-1:0] ram_addr;
   byte_t             ram_wdata;
   byte_t             ram_rdata;

   // one request bus per memory master
   mem_req_if dec_bus ();
   mem_req_if fill_bus ();

   mcu_cmd_decoder #(
      .CREDITS (CREDITS)
   ) u_mcu_cmd_decoder (
      .clk         (clk),
      .rst         (rst),
      .byte_valid  (byte_valid),
      .byte_first  (byte_first),
      .byte_in     (byte_in),
      .fill_busy   (fill_busy),
      .reply_valid (reply_valid),
      .reply_byte  (reply_byte),
      .fill_start  (fill_start),
      .fill_addr   (fill_addr),
      .fill_mask   (fill_mask),
      .fill_len    (fill_len),
      .fill_value  (fill_value),
      .mem         (dec_bus.requester)
   );

   fill_engine #(
      .CREDITS (CREDITS)
   ) u_fill_engine (
      .clk        (clk),
      .rst        (rst),
      .fill_start (fill_start),
      .fill_addr  (fill_addr),
      .fill_mask  (fill_mask),
      .fill_len   (fill_len),
      .fill_value (fill_value),
      .fill_busy  (fill_busy),
      .mem        (fill_bus.requester)
   );

   mem_arbiter #(
      .ADDR_W  (ADDR_W),
      .CREDITS (CREDITS)
   ) u_mem_arbiter (
      .clk       (clk),
      .rst       (rst),
      .dec       (dec_bus.arbiter),
      .fill      (fill_bus.arbiter),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   save_ram #(
      .ADDR_W (ADDR_W)
   ) u_save_ram (
      .clk       (clk),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

endmodule

// ==== dv/cart_checker.sv ====
`timescale 1ns/1ps

module cart_checker
   import cart_pkg::*;
(
   input logic  clk,
   input logic  rst,
   input logic  byte_valid,
   input logic  byte_first,
   input byte_t byte_in,
   input logic  reply_valid,
   input byte_t reply_byte,
   input logic  fill_busy
);

   byte_t exp_q [$];
   int    errors = 0;
   int    checks = 0;
   logic  info_frame = 1'b0;
   logic  info_prev = 1'b0;

   function automatic void push_expect(input byte_t b);
      exp_q.push_back(b);
   endfunction

   function automatic int pending();
      return exp_q.size();
   endfunction

   task automatic check_busy(input logic exp);
      @(negedge clk);
      checks++;
      if (fill_busy !== exp) begin
         $display("[FAIL] t=%0t fill_busy expected %0b got %0b", $time, exp, fill_busy);
         errors++;
      end
   endtask

   ////////////////////
   // reply compare
   ////////////////////

   // sampled at the falling edge, where DUT outputs are settled
   always @(negedge clk) begin : compare
      byte_t exp;
      if (rst) begin
         info_frame = 1'b0;
         info_prev  = 1'b0;
      end else begin
         // an info byte must be answered on the very next cycle
         if (info_frame && (reply_valid !== info_prev)) begin
            $display("t=%0t info reply did not follow its parameter byte by one cycle",
                     $time);
            errors++;
         end
         if (reply_valid) begin
            if (exp_q.size() == 0) begin
               $display("t=%0t reply arrived while no reply was expected", $time);
               errors++;
            end else begin
               exp = exp_q.pop_front();
               checks++;
               if (reply_byte !== exp) begin
                  $display("[FAIL] t=%0t reply_byte expected 0x%02h got 0x%02h",
                           $time, exp, reply_byte);
                  errors++;
               end
            end
         end
         info_prev = info_frame && byte_valid && !byte_first;
         if (byte_valid && byte_first) begin
            info_frame = (byte_in[7:4] == 4'hF);
         end
      end
   end

endmodule

// ==== dv/tb_cart_cmd.sv ====
`timescale 1ns/1ps

module tb_cart_cmd
   import cart_pkg::*;
();

   // frames per test with read-backs in chunks of 16 bytes
   localparam int FRAMES = 2 + 4 + 10 + (8 + 2 * ((302 + 15) / 16)) +
                           (4 + 2 * ((200 + 15) / 16) + 2);

   logic  clk = 1'b0;
   logic  rst = 1'b1;
   logic  byte_valid = 1'b0;
   logic  byte_first = 1'b0;
   byte_t byte_in = '0;
   logic  reply_valid;
   byte_t reply_byte;
   logic  fill_busy;

   // reference model state
   byte_t ref_mem [int];
   byte_t frame_q [$];
   addr_t m_ptr = '0;
   addr_t m_mask = '1;
   byte_t m_cmd = '0;
   int    m_idx = 0;
   len_t  m_len = '0;
   logic  m_busy = 1'b0;

   int    n_tests = 0;
   int    n_pass = 0;
   int    err_mark = 0;
   addr_t waddr;

   always #2 clk = ~clk;

   cart_cmd_top u_cart_cmd_top (
      .clk         (clk),
      .rst         (rst),
      .byte_valid  (byte_valid),
      .byte_first  (byte_first),
      .byte_in     (byte_in),
      .reply_valid (reply_valid),
      .reply_byte  (reply_byte),
      .fill_busy   (fill_busy)
   );

   cart_checker u_checker (
      .clk         (clk),
      .rst         (rst),
      .byte_valid  (byte_valid),
      .byte_first  (byte_first),
      .byte_in     (byte_in),
      .reply_valid (reply_valid),
      .reply_byte  (reply_byte),
      .fill_busy   (fill_busy)
   );

   ////////////////////
   // reference model
   ////////////////////

   // masked pointer cut to the 12-bit RAM
   function automatic int ram_index(input addr_t a);
      return int'((a & m_mask) & 24'h000FFF);
   endfunction

   // returns 1 when the byte should produce a reply and puts its value in exp
   function automatic logic model_byte(input logic first, input byte_t b, output byte_t exp);
      logic rep;
      int   a;
      rep = 1'b0;
      exp = '0;
      if (first) begin
         m_cmd = b;
         m_idx = 0;
         return 1'b0;
      end
      case (m_cmd[7:4])
         4'h0, 4'h1: begin
            if (m_cmd[4]) begin
               if (m_idx == 0) m_mask = {b, 16'h0000};
               if (m_idx == 1) m_mask[15:8] = b;
               if (m_idx == 2) m_mask[7:0] = b;
            end else begin
               if (m_idx == 0) m_ptr = {b, 16'h0000};
               if (m_idx == 1) m_ptr[15:8] = b;
               if (m_idx == 2) m_ptr[7:0] = b;
            end
         end
         4'h9: begin
            ref_mem[ram_index(m_ptr)] = b;
            m_ptr = m_ptr + 24'd1;
         end
         4'h8: begin
            a   = ram_index(m_ptr);
            exp = ref_mem.exists(a) ? ref_mem[a] : 8'hxx;
            rep = 1'b1;
            m_ptr = m_ptr + 24'd1;
         end
         4'h4: begin
            if (m_idx == 0) m_len[15:8] = b;
            if (m_idx == 1) m_len[7:0] = b;
            if ((m_idx == 2) && !m_busy && (m_len != 0)) begin
               for (int i = 0; i < m_len; i++) begin
                  ref_mem[ram_index(m_ptr + addr_t'(i))] = b;
               end
               m_busy = 1'b1;
            end
         end
         4'hF: begin
            rep = 1'b1;
            exp = (m_cmd[3:0] == 4'h1) ? {m_busy, 7'b0} : 8'hA5;
         end
         default: ;
      endcase
      if (m_idx != 3) m_idx++;
      return rep;
   endfunction

   ////////////////////
   // frame stimulus
   ////////////////////

   task automatic send_frame();
      byte_t exp;
      for (int i = 0; i < frame_q.size(); i++) begin
         @(posedge clk);
         #1;
         byte_valid = 1'b1;
         byte_first = (i == 0);
         byte_in    = frame_q[i];
         if (model_byte(i == 0, frame_q[i], exp)) begin
            u_checker.push_expect(exp);
         end
         @(posedge clk);
         #1;
         byte_valid = 1'b0;
         byte_first = 1'b0;
         // 4 to 7 cycles between bytes
         repeat ($urandom_range(5, 2)) @(posedge clk);
      end
      while (u_checker.pending() != 0) @(posedge clk);
      frame_q.delete();
   endtask

   task automatic set_reg(input byte_t cmd, input addr_t v);
      frame_q.push_back(cmd);
      frame_q.push_back(v[23:16]);
      frame_q.push_back(v[15:8]);
      frame_q.push_back(v[7:0]);
      send_frame();
   endtask

   task automatic write_block(input addr_t a, input int n);
      set_reg(8'h00, a);
      frame_q.push_back(8'h90);
      repeat (n) frame_q.push_back(byte_t'($urandom_range(255, 0)));
      send_frame();
   endtask

   task automatic read_back(input addr_t a, input int n);
      int done;
      int chunk;
      done = 0;
      while (done < n) begin
         chunk = ((n - done) > 16) ? 16 : (n - done);
         set_reg(8'h00, a + addr_t'(done));
         frame_q.push_back(8'h80);
         repeat (chunk) frame_q.push_back(8'h00);
         send_frame();
         done += chunk;
      end
   endtask

   task automatic info_frame(input byte_t cmd, input int n);
      frame_q.push_back(cmd);
      repeat (n) frame_q.push_back(8'h00);
      send_frame();
   endtask

   task automatic start_fill(input addr_t a, input len_t len, input byte_t v);
      set_reg(8'h00, a);
      frame_q.push_back(8'h40);
      frame_q.push_back(len[15:8]);
      frame_q.push_back(len[7:0]);
      frame_q.push_back(v);
      send_frame();
   endtask

   task automatic wait_fill_done();
      while (fill_busy) @(negedge clk);
      m_busy = 1'b0;
   endtask

   task automatic end_test(input string name);
      n_tests++;
      if (u_checker.errors == err_mark) begin
         n_pass++;
         $display("test %0d %s: passed", n_tests, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", n_tests, name,
                  u_checker.errors - err_mark);
      end
      err_mark = u_checker.errors;
   endtask

   ////////////////////
   // test sequence
   ////////////////////

   initial begin
      void'($urandom(43693));
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      u_checker.check_busy(1'b0);
      info_frame(8'hF0, 4);
      info_frame(8'hF1, 2);
      end_test("identity and idle status");

      write_block(24'h0000F0, 16);
      read_back(24'h0000F0, 16);
      end_test("write and read back");

      // wraps from 0xFF to 0x00 under the mask
      set_reg(8'h10, 24'h0000FF);
      write_block(24'h0000F8, 16);
      read_back(24'h0000F0, 24);
      set_reg(8'h10, 24'hFFFFFF);
      // the wrapped bytes sit at the bottom of the unmasked RAM
      read_back(24'h000000, 8);
      end_test("address mask wrap");

      write_block(24'h0001FF, 1);
      write_block(24'h00032C, 1);
      start_fill(24'h000200, 16'd300, byte_t'($urandom_range(255, 0)));
      u_checker.check_busy(1'b1);
      info_frame(8'hF1, 2);
      wait_fill_done();
      info_frame(8'hF1, 1);
      read_back(24'h0001FF, 302);
      end_test("fill and status");

      waddr = 24'h000800 + addr_t'($urandom_range(12'h7E0, 0));
      start_fill(24'h000400, 16'd200, byte_t'($urandom_range(255, 0)));
      u_checker.check_busy(1'b1);
      write_block(waddr, 16);
      wait_fill_done();
      read_back(24'h000400, 200);
      read_back(waddr, 16);
      end_test("writes during fill");

      $display("%0d of %0d tests passed, %0d checks, %0d errors",
               n_pass, n_tests, u_checker.checks, u_checker.errors);
      if (u_checker.errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (FRAMES * 200) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", FRAMES * 200);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== all.f ====
rtl/cart_pkg.sv
rtl/mem_req_if.sv
rtl/mcu_cmd_decoder.sv
rtl/fill_engine.sv
rtl/mem_arbiter.sv
rtl/save_ram.sv
rtl/cart_cmd_top.sv
dv/cart_checker.sv
dv/tb_cart_cmd.sv
